//--- src/vin_pkg.sv
// Video input package with shared widths and the mode and state encodings
`default_nettype none

package vin_pkg;

    // One DPI pixel, R in the top byte and B in the bottom byte
    localparam int PIX_W = 24;

    // Pixels carried in one double-pixel word, also the lane count
    localparam int PIXELS_PER_WORD = 2;

    // One converted pixel
    localparam int LANE_W = 16;

    // Conversion opcode for each lane
    typedef enum logic {
        MODE_RGB565 = 1'b0,
        MODE_LUMA   = 1'b1
    } pix_mode_e;

    // Which pixel of a pair the pair former is waiting for
    typedef enum logic {
        PH_FIRST  = 1'b0,
        PH_SECOND = 1'b1
    } pair_phase_e;

    // Startup frame discard state
    typedef enum logic {
        SKIPPING = 1'b0,
        RUNNING  = 1'b1
    } skip_state_e;

endpackage

`default_nettype wire

//--- src/vin_pixel_pair.sv
// DPI pair former that samples the bus, drops startup frames and builds double-pixel words
`default_nettype none

module vin_pixel_pair import vin_pkg::*; #(
    parameter int SKIP_FRAMES  = 3,
    parameter int H_ACTIVE_MAX = 400,
    parameter int CNT_W        = 11
) (
    input  wire                             pclk,
    input  wire                             vi_rst,
    input  wire                             dpi_vsync,
    input  wire                             dpi_hsync,
    input  wire                             dpi_de,
    input  wire [PIX_W-1:0]                 dpi_pixel,
    output logic                            pair_valid,
    output logic                            pair_de,
    output logic                            pair_hsync,
    output logic                            pair_vsync,
    output logic [PIXELS_PER_WORD*PIX_W-1:0] pair_pixel
);

    // Enough bits to count up to SKIP_FRAMES discarded vsync edges
    localparam int SKIP_W = (SKIP_FRAMES > 0) ? $clog2(SKIP_FRAMES + 1) : 1;

    logic              de_q;
    logic              hsync_q;
    logic              vsync_q;
    logic [PIX_W-1:0]  pix_q;
    logic              de_last;
    logic              vsync_last;
    logic              de_rise;
    logic              vsync_rise;

    pair_phase_e       phase;
    skip_state_e       skip_state;
    logic [SKIP_W-1:0] skip_cnt;
    logic              skip_end;
    logic              running;

    logic [PIX_W-1:0]  pix_buf;
    logic [CNT_W-1:0]  pair_cnt;

    // Input register stage
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            de_q       <= 1'b0;
            hsync_q    <= 1'b0;
            vsync_q    <= 1'b0;
            pix_q      <= '0;
            de_last    <= 1'b0;
            vsync_last <= 1'b0;
        end else begin
            de_q       <= dpi_de;
            hsync_q    <= dpi_hsync;
            vsync_q    <= dpi_vsync;
            pix_q      <= dpi_pixel;
            de_last    <= de_q;
            vsync_last <= vsync_q;
        end
    end

    assign de_rise    = de_q & ~de_last;
    assign vsync_rise = vsync_q & ~vsync_last;

    // The vsync edge after the first SKIP_FRAMES ones opens the output
    assign skip_end = (skip_state == SKIPPING) && vsync_rise
                      && (skip_cnt == SKIP_W'(SKIP_FRAMES));
    assign running  = (skip_state == RUNNING) || skip_end;

    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            skip_state <= SKIPPING;
            skip_cnt   <= '0;
        end else if (skip_end) begin
            skip_state <= RUNNING;
        end else if ((skip_state == SKIPPING) && vsync_rise) begin
            skip_cnt <= skip_cnt + 1'b1;
        end
    end

    // Pair phase, line limit and sync outputs
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            phase      <= PH_FIRST;
            pair_valid <= 1'b0;
            pair_de    <= 1'b0;
            pair_hsync <= 1'b0;
            pair_vsync <= 1'b0;
            pair_cnt   <= '0;
        end else if (de_rise || (phase == PH_FIRST)) begin
            // A new line always starts on the first pixel of a pair
            phase      <= PH_SECOND;
            pair_valid <= 1'b0;
            if (de_rise) begin
                pair_cnt <= '0;
            end
        end else begin
            phase      <= PH_FIRST;
            pair_valid <= 1'b1;
            pair_hsync <= hsync_q & running;
            pair_vsync <= vsync_q & running;
            if (de_q && running && (pair_cnt < CNT_W'(H_ACTIVE_MAX))) begin
                pair_de  <= 1'b1;
                pair_cnt <= pair_cnt + 1'b1;
            end else begin
                // Past the limit de stays low until the next line
                pair_de <= 1'b0;
            end
        end
    end

    // First pixel buffer and word assembly with the earlier pixel on top
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            pix_buf    <= '0;
            pair_pixel <= '0;
        end else if (de_rise || (phase == PH_FIRST)) begin
            pix_buf <= pix_q;
        end else begin
            pair_pixel <= {pix_buf, pix_q};
        end
    end

endmodule

`default_nettype wire

//--- src/vin_pixel_lane.sv
// Pixel lane that converts one RGB888 pixel to RGB565 or 8-bit luma
`default_nettype none

module vin_pixel_lane import vin_pkg::*; (
    input  wire              pclk,
    input  wire              vi_rst,
    input  wire pix_mode_e   pix_mode,
    input  wire              in_valid,
    input  wire [PIX_W-1:0]  in_pixel,
    output logic             lane_valid,
    output logic [LANE_W-1:0] lane_data
);

    logic [7:0]        red;
    logic [7:0]        green;
    logic [7:0]        blue;
    logic [10:0]       luma_sum;
    logic [LANE_W-1:0] conv_data;

    assign red   = in_pixel[23:16];
    assign green = in_pixel[15:8];
    assign blue  = in_pixel[7:0];

    // 2R + 5G + B peaks at 2040 and fits in 11 bits
    assign luma_sum = (11'(red) << 1) + (11'(green) * 11'd5) + 11'(blue);

    always_comb begin
        conv_data = '0;
        case (pix_mode)
            MODE_RGB565: conv_data = {red[7:3], green[7:2], blue[7:3]};
            MODE_LUMA:   conv_data = {8'h00, luma_sum[10:3]};
            default:     conv_data = '0;
        endcase
    end

    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            lane_valid <= 1'b0;
            lane_data  <= '0;
        end else begin
            lane_valid <= in_valid;
            lane_data  <= conv_data;
        end
    end

endmodule

`default_nettype wire

//--- src/vin_line_collect.sv
// Line collector that packs lane results and counts pairs per line and lines per frame
`default_nettype none

module vin_line_collect import vin_pkg::*; #(
    parameter int CNT_W = 11
) (
    input  wire                                          pclk,
    input  wire                                          vi_rst,
    input  wire [PIXELS_PER_WORD-1:0]                    lane_valid,
    input  wire [PIXELS_PER_WORD-1:0][LANE_W-1:0]        lane_data,
    input  wire                                          sync_de,
    input  wire                                          sync_hsync,
    input  wire                                          sync_vsync,
    output logic                                         out_valid,
    output logic                                         out_de,
    output logic                                         out_hsync,
    output logic                                         out_vsync,
    output logic [PIXELS_PER_WORD*LANE_W-1:0]            out_data,
    output logic                                         line_done,
    output logic [CNT_W-1:0]                             line_pairs,
    output logic                                         frame_done,
    output logic [CNT_W-1:0]                             frame_lines
);

    logic                              de_d;
    logic                              hsync_d;
    logic                              vsync_d;
    logic                              pair_inc;
    logic                              line_end;
    logic                              frame_start;
    logic [CNT_W-1:0]                  pair_cnt;
    logic [CNT_W-1:0]                  line_cnt;
    logic [PIXELS_PER_WORD*LANE_W-1:0] packed_data;

    // Syncs wait one cycle to line up with the lane register
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            de_d    <= 1'b0;
            hsync_d <= 1'b0;
            vsync_d <= 1'b0;
        end else begin
            de_d    <= sync_de;
            hsync_d <= sync_hsync;
            vsync_d <= sync_vsync;
        end
    end

    // Lane 0 carries the earlier pixel and lands in the upper half
    always_comb begin
        packed_data = '0;
        for (int i = 0; i < PIXELS_PER_WORD; i++) begin
            packed_data[(PIXELS_PER_WORD-1-i)*LANE_W +: LANE_W] = lane_data[i];
        end
    end

    // Edges are taken on the values about to enter the output register
    assign pair_inc    = lane_valid[0] & de_d;
    assign line_end    = out_de & ~de_d;
    assign frame_start = vsync_d & ~out_vsync;

    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            out_valid  <= 1'b0;
            out_de     <= 1'b0;
            out_hsync  <= 1'b0;
            out_vsync  <= 1'b0;
            out_data   <= '0;
            line_done  <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            out_valid  <= lane_valid[0];
            out_de     <= de_d;
            out_hsync  <= hsync_d;
            out_vsync  <= vsync_d;
            out_data   <= packed_data;
            line_done  <= line_end;
            frame_done <= frame_start;
        end
    end

    // Pairs on the current line are latched when de falls
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            pair_cnt   <= '0;
            line_pairs <= '0;
        end else if (line_end) begin
            line_pairs <= pair_cnt;
            pair_cnt   <= '0;
        end else if (pair_inc) begin
            pair_cnt <= pair_cnt + 1'b1;
        end
    end

    // Lines since the last frame start include a line that ends on the same cycle
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            line_cnt    <= '0;
            frame_lines <= '0;
        end else if (frame_start) begin
            frame_lines <= line_cnt + CNT_W'(line_end);
            line_cnt    <= '0;
        end else if (line_end) begin
            line_cnt <= line_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/vin_top.sv
// DPI video input top that chains the pair former, the pixel lanes and the line collector
`default_nettype none

module vin_top import vin_pkg::*; #(
    parameter int SKIP_FRAMES  = 3,
    parameter int H_ACTIVE_MAX = 400,
    parameter int CNT_W        = 11
) (
    input  wire                               pclk,
    input  wire                               vi_rst,
    input  wire                               dpi_vsync,
    input  wire                               dpi_hsync,
    input  wire                               dpi_de,
    input  wire [PIX_W-1:0]                   dpi_pixel,
    input  wire pix_mode_e                    pix_mode,
    output logic                              out_valid,
    output logic                              out_de,
    output logic                              out_hsync,
    output logic                              out_vsync,
    output logic [PIXELS_PER_WORD*LANE_W-1:0] out_data,
    output logic                              line_done,
    output logic [CNT_W-1:0]                  line_pairs,
    output logic                              frame_done,
    output logic [CNT_W-1:0]                  frame_lines
);

    logic                                  pair_valid;
    logic                                  pair_de;
    logic                                  pair_hsync;
    logic                                  pair_vsync;
    logic [PIXELS_PER_WORD*PIX_W-1:0]      pair_pixel;
    logic [PIXELS_PER_WORD-1:0]            lane_valid;
    logic [PIXELS_PER_WORD-1:0][LANE_W-1:0] lane_data;

    vin_pixel_pair #(
        .SKIP_FRAMES  (SKIP_FRAMES),
        .H_ACTIVE_MAX (H_ACTIVE_MAX),
        .CNT_W        (CNT_W)
    ) u_pair (
        .pclk       (pclk),
        .vi_rst     (vi_rst),
        .dpi_vsync  (dpi_vsync),
        .dpi_hsync  (dpi_hsync),
        .dpi_de     (dpi_de),
        .dpi_pixel  (dpi_pixel),
        .pair_valid (pair_valid),
        .pair_de    (pair_de),
        .pair_hsync (pair_hsync),
        .pair_vsync (pair_vsync),
        .pair_pixel (pair_pixel)
    );

    // Lane 0 takes the upper, earlier pixel
    for (genvar i = 0; i < PIXELS_PER_WORD; i++) begin : g_lane
        vin_pixel_lane u_lane (
            .pclk       (pclk),
            .vi_rst     (vi_rst),
            .pix_mode   (pix_mode),
            .in_valid   (pair_valid),
            .in_pixel   (pair_pixel[(PIXELS_PER_WORD-1-i)*PIX_W +: PIX_W]),
            .lane_valid (lane_valid[i]),
            .lane_data  (lane_data[i])
        );
    end

    vin_line_collect #(
        .CNT_W (CNT_W)
    ) u_collect (
        .pclk        (pclk),
        .vi_rst      (vi_rst),
        .lane_valid  (lane_valid),
        .lane_data   (lane_data),
        .sync_de     (pair_de),
        .sync_hsync  (pair_hsync),
        .sync_vsync  (pair_vsync),
        .out_valid   (out_valid),
        .out_de      (out_de),
        .out_hsync   (out_hsync),
        .out_vsync   (out_vsync),
        .out_data    (out_data),
        .line_done   (line_done),
        .line_pairs  (line_pairs),
        .frame_done  (frame_done),
        .frame_lines (frame_lines)
    );

endmodule

`default_nettype wire

//--- tb/vin_assertions.sv
// Concurrent checks on vin_top for reset state, frame skipping, conversion and strobe spacing
`default_nettype none

module vin_assertions import vin_pkg::*; #(
    parameter int SKIP_FRAMES = 3
) (
    input wire                              pclk,
    input wire                              vi_rst,
    input wire                              dpi_vsync,
    input wire [PIX_W-1:0]                  dpi_pixel,
    input wire pix_mode_e                   pix_mode,
    input wire                              out_valid,
    input wire                              out_de,
    input wire                              out_hsync,
    input wire                              out_vsync,
    input wire [PIXELS_PER_WORD*LANE_W-1:0] out_data,
    input wire                              line_done,
    input wire                              frame_done
);

    int   fail_count = 0;
    logic vsync_prev;
    int   vsync_seen;

    // Reference conversion of one RGB888 pixel
    function automatic logic [LANE_W-1:0] expected_lane(input pix_mode_e mode,
                                                        input logic [PIX_W-1:0] pixel);
        int r;
        int g;
        int b;
        int y;
        r = pixel[23:16];
        g = pixel[15:8];
        b = pixel[7:0];
        y = (2 * r + 5 * g + b) / 8;
        if (mode == MODE_LUMA) begin
            return {8'h00, y[7:0]};
        end
        return {pixel[23:19], pixel[15:10], pixel[7:3]};
    endfunction

    // Vsync rising edges seen on the DPI bus since reset
    always_ff @(posedge pclk or posedge vi_rst) begin
        if (vi_rst) begin
            vsync_prev <= 1'b0;
            vsync_seen <= 0;
        end else begin
            vsync_prev <= dpi_vsync;
            if (dpi_vsync && !vsync_prev) begin
                vsync_seen <= vsync_seen + 1;
            end
        end
    end

    a_reset_quiet: assert property (
        @(posedge pclk) $fell(vi_rst) |->
            !(out_valid || out_de || out_hsync || out_vsync || line_done || frame_done)
    ) else begin
        fail_count = fail_count + 1;
        $error("Outputs not low right after reset");
    end

    a_skip_frames: assert property (
        @(posedge pclk) disable iff (vi_rst)
        (vsync_seen <= SKIP_FRAMES) |-> !(out_de || out_hsync || out_vsync)
    ) else begin
        fail_count = fail_count + 1;
        $error("Sync output active while startup frames are still discarded");
    end

    // Upper half is the earlier pixel and the lanes convert two cycles before the output
    a_data_rule: assert property (
        @(posedge pclk) disable iff (vi_rst)
        (out_valid && out_de) |->
            (out_data[31:16] == expected_lane($past(pix_mode, 2), $past(dpi_pixel, 5))) &&
            (out_data[15:0] == expected_lane($past(pix_mode, 2), $past(dpi_pixel, 4)))
    ) else begin
        fail_count = fail_count + 1;
        $error("Error: a_data_rule expected %h actual %h",
               {expected_lane($past(pix_mode, 2), $past(dpi_pixel, 5)),
                expected_lane($past(pix_mode, 2), $past(dpi_pixel, 4))},
               $sampled(out_data));
    end

    a_valid_spacing: assert property (
        @(posedge pclk) disable iff (vi_rst) out_valid |=> !out_valid
    ) else begin
        fail_count = fail_count + 1;
        $error("out_valid was high on two consecutive cycles");
    end

endmodule

`default_nettype wire

//--- tb/tb_vin.sv
// Testbench for vin_top with a DPI frame generator and line and frame count checks
`default_nettype none

module tb_vin;
    import vin_pkg::*;

    localparam int SKIP_FRAMES     = 2;
    localparam int H_ACTIVE_MAX    = 8;
    localparam int CNT_W           = 11;
    localparam int LINES_PER_FRAME = 4;
    localparam int HBLANK          = 6;
    localparam int TIMEOUT         = 500;

    logic                              pclk;
    logic                              vi_rst;
    logic                              dpi_vsync;
    logic                              dpi_hsync;
    logic                              dpi_de;
    logic [PIX_W-1:0]                  dpi_pixel;
    pix_mode_e                         pix_mode;
    logic                              out_valid;
    logic                              out_de;
    logic                              out_hsync;
    logic                              out_vsync;
    logic [PIXELS_PER_WORD*LANE_W-1:0] out_data;
    logic                              line_done;
    logic [CNT_W-1:0]                  line_pairs;
    logic                              frame_done;
    logic [CNT_W-1:0]                  frame_lines;

    integer seed = 32'h5137_298a;
    int     line_expect[$];
    int     lines_checked = 0;
    int     frames_seen = 0;
    int     hsync_pulses = 0;
    logic   hsync_last = 1'b0;
    int     frame_idx;
    int     cycles;

    vin_top #(
        .SKIP_FRAMES  (SKIP_FRAMES),
        .H_ACTIVE_MAX (H_ACTIVE_MAX),
        .CNT_W        (CNT_W)
    ) DUT (.*);

    bind vin_top vin_assertions #(.SKIP_FRAMES(SKIP_FRAMES)) u_vin_assert (.*);

    initial begin
        pclk = 1'b0;
        forever #5 pclk = ~pclk;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (expected != actual) begin
            abort_run($sformatf("Error: %s expected %0d actual %0d", name, expected, actual));
        end
    endtask

    task automatic drive_cycle(input logic vs, input logic hs, input logic de,
                               input logic [PIX_W-1:0] pix);
        @(posedge pclk);
        #1;
        dpi_vsync = vs;
        dpi_hsync = hs;
        dpi_de    = de;
        dpi_pixel = pix;
    endtask

    task automatic send_vsync();
        repeat (4) drive_cycle(1'b1, 1'b0, 1'b0, '0);
        repeat (3) drive_cycle(1'b0, 1'b0, 1'b0, '0);
    endtask

    // Lines of a skipped frame never reach the output
    task automatic send_frame(input int pixels, input bit running);
        int expected;
        expected = pixels / 2;
        if (expected > H_ACTIVE_MAX) begin
            expected = H_ACTIVE_MAX;
        end
        send_vsync();
        for (int line = 0; line < LINES_PER_FRAME; line++) begin
            if (running) begin
                line_expect.push_back(expected);
            end
            for (int px = 0; px < pixels; px++) begin
                drive_cycle(1'b0, 1'b0, 1'b1, PIX_W'($random(seed)));
            end
            repeat (HBLANK) drive_cycle(1'b0, 1'b1, 1'b0, '0);
        end
        repeat (2) drive_cycle(1'b0, 1'b0, 1'b0, '0);
        frame_idx++;
    endtask

    always @(posedge pclk) begin
        if (DUT.u_vin_assert.fail_count != 0) begin
            abort_run("A concurrent assertion on vin_top failed");
        end else if (!vi_rst && line_done) begin
            if (line_expect.size() == 0) begin
                abort_run("line_done pulsed with no line outstanding");
            end else begin
                check_count("line_pairs", line_expect.pop_front(), int'(line_pairs));
                lines_checked++;
            end
        end
    end

    // The first frame_done after skipping closes a discarded frame
    always @(posedge pclk) begin
        if (!vi_rst && frame_done) begin
            frames_seen++;
            if (frames_seen > 1) begin
                check_count("frame_lines", LINES_PER_FRAME, int'(frame_lines));
                check_count("hsync_pulses", LINES_PER_FRAME, hsync_pulses);
            end
            hsync_pulses = 0;
        end
        // One output hsync pulse is expected per line
        if (!vi_rst && out_hsync && !hsync_last) begin
            hsync_pulses++;
        end
        hsync_last = out_hsync;
    end

    initial begin
        vi_rst    = 1'b1;
        dpi_vsync = 1'b0;
        dpi_hsync = 1'b0;
        dpi_de    = 1'b0;
        dpi_pixel = '0;
        pix_mode  = MODE_RGB565;
        frame_idx = 0;
        repeat (16) @(posedge pclk);
        #1;
        vi_rst = 1'b0;

        while (frame_idx < SKIP_FRAMES) begin
            send_frame(12, 1'b0);
        end
        send_frame(12, 1'b1);
        pix_mode = MODE_LUMA;
        send_frame(12, 1'b1);
        send_frame(20, 1'b1);
        pix_mode = MODE_RGB565;
        send_frame(20, 1'b1);
        // Trailing vsync reports the line count of the last frame
        send_vsync();

        cycles = 0;
        while ((lines_checked < 4 * LINES_PER_FRAME || frames_seen < 5) && cycles < TIMEOUT) begin
            @(posedge pclk);
            cycles++;
        end
        if (lines_checked < 4 * LINES_PER_FRAME || frames_seen < 5) begin
            abort_run("Timeout waiting for the last line_done and frame_done pulses");
        end else if (DUT.u_vin_assert.fail_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("A concurrent assertion on vin_top failed");
        end
    end

endmodule

`default_nettype wire

//--- vlog.f
src/vin_pkg.sv
src/vin_pixel_pair.sv
src/vin_pixel_lane.sv
src/vin_line_collect.sv
src/vin_top.sv
tb/vin_assertions.sv
tb/tb_vin.sv
